// File: hw/bus_pkg.sv
// Wishbone request and response types, region map, bus FSM states and access type

package bus_pkg;

   // ******************************
   // Bus geometry
   // ******************************
   localparam int DATA_W  = 32;
   localparam int ADR_W   = 6;
   localparam int OFF_W   = 4;
   // Upper address bits select the region
   localparam int RGN_LSB = OFF_W;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADR_W-1:0]  adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      RGN_SYS  = 2'd0,
      RGN_GPIO = 2'd1,
      RGN_PWM  = 2'd2,
      RGN_NONE = 2'd3
   } region_e;

   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_ACK  = 1'b1
   } bus_state_e;

   // Decoded access handed to one peripheral
   typedef struct packed {
      logic              wr;
      logic [OFF_W-1:0]  off;
      logic [DATA_W-1:0] wdat;
   } reg_acc_t;

endpackage

// File: hw/periph_pkg.sv
// Peripheral widths, register offset maps, version value and interrupt bit positions

package periph_pkg;

   localparam int GPIO_W = 32;
   localparam int IRQ_W  = 8;

   localparam logic [31:0] SYS_VERSION = 32'h0001_0100;

   // ******************************
   // Register offsets
   // ******************************
   typedef enum logic [3:0] {
      SYS_VER     = 4'd0,
      SYS_SCRATCH = 4'd1,
      SYS_STATUS  = 4'd2,
      SYS_SWIRQ   = 4'd3
   } sys_reg_e;

   typedef enum logic [3:0] {
      GPIO_IN  = 4'd0,
      GPIO_OUT = 4'd1,
      GPIO_OE  = 4'd2,
      GPIO_IE  = 4'd3,
      GPIO_IS  = 4'd4
   } gpio_reg_e;

   typedef enum logic [3:0] {
      PWM_CNTR = 4'd0,
      PWM_HRC  = 4'd1,
      PWM_LRC  = 4'd2,
      PWM_CTRL = 4'd3
   } pwm_reg_e;

   // Interrupt vector bit positions
   localparam int IRQ_GPIO = 0;
   localparam int IRQ_PWM  = 1;
   localparam int IRQ_SW3  = 2;
   localparam int IRQ_SW4  = 3;

endpackage

// File: hw/wb_decoder.sv
// Wishbone slave controller with region decode, single-cycle ack and read data mux
`timescale 1ns/10ps

module wb_decoder (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  bus_pkg::wb_req_t            i_req,
   output bus_pkg::wb_rsp_t            o_rsp,
   output bus_pkg::reg_acc_t           o_sys_acc,
   output bus_pkg::reg_acc_t           o_gpio_acc,
   output bus_pkg::reg_acc_t           o_pwm_acc,
   input  logic [bus_pkg::DATA_W-1:0]  i_sys_rdat,
   input  logic [bus_pkg::DATA_W-1:0]  i_gpio_rdat,
   input  logic [bus_pkg::DATA_W-1:0]  i_pwm_rdat
);

   bus_pkg::bus_state_e         state;
   bus_pkg::bus_state_e         state_n;
   bus_pkg::region_e            region;
   bus_pkg::reg_acc_t           acc;
   bus_pkg::wb_rsp_t            rsp_q;
   logic                        take;
   logic [bus_pkg::DATA_W-1:0]  rdat_sel;

   assign region = bus_pkg::region_e'(i_req.adr[bus_pkg::ADR_W-1:bus_pkg::RGN_LSB]);

   // New request only accepted in idle
   assign take = (state == bus_pkg::ST_IDLE) && i_req.cyc && i_req.stb;

   // ******************************
   // Access fan-out
   // ******************************
   always_comb begin
      acc.wr   = take && i_req.we;
      acc.off  = i_req.adr[bus_pkg::OFF_W-1:0];
      acc.wdat = i_req.dat;

      o_sys_acc     = acc;
      o_gpio_acc    = acc;
      o_pwm_acc     = acc;
      o_sys_acc.wr  = acc.wr && (region == bus_pkg::RGN_SYS);
      o_gpio_acc.wr = acc.wr && (region == bus_pkg::RGN_GPIO);
      o_pwm_acc.wr  = acc.wr && (region == bus_pkg::RGN_PWM);
   end

   always_comb begin
      case (region)
         bus_pkg::RGN_SYS:  rdat_sel = i_sys_rdat;
         bus_pkg::RGN_GPIO: rdat_sel = i_gpio_rdat;
         bus_pkg::RGN_PWM:  rdat_sel = i_pwm_rdat;
         default:           rdat_sel = '0;
      endcase
   end

   // ******************************
   // Bus FSM
   // ******************************
   always_comb begin
      state_n = state;
      case (state)
         bus_pkg::ST_IDLE: if (take) state_n = bus_pkg::ST_ACK;
         bus_pkg::ST_ACK:  state_n = bus_pkg::ST_IDLE;
         default:          state_n = bus_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= bus_pkg::ST_IDLE;
         rsp_q <= '0;
      end else begin
         state     <= state_n;
         rsp_q.ack <= take;
         rsp_q.err <= take && (region == bus_pkg::RGN_NONE);
         if (take) begin
            rsp_q.dat <= rdat_sel;
         end
      end
   end

   assign o_rsp = rsp_q;

endmodule

// File: hw/sys_ctrl.sv
// System controller registers and interrupt vector assembly
`timescale 1ns/10ps

module sys_ctrl (
   input  logic                            i_clk,
   input  logic                            i_rst_n,
   input  bus_pkg::reg_acc_t               i_acc,
   output logic [bus_pkg::DATA_W-1:0]      o_rdat,
   input  logic                            i_init_done,
   input  logic                            i_init_error,
   input  logic                            i_gpio_irq,
   input  logic                            i_pwm_irq,
   output logic [periph_pkg::IRQ_W-1:0]    o_irq
);

   periph_pkg::sys_reg_e         reg_sel;
   logic [bus_pkg::DATA_W-1:0]   scratch;
   // bit 0 drives sw3, bit 1 drives sw4
   logic [1:0]                   sw_irq;

   assign reg_sel = periph_pkg::sys_reg_e'(i_acc.off);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         scratch <= '0;
         sw_irq  <= '0;
      end else if (i_acc.wr) begin
         if (reg_sel == periph_pkg::SYS_SCRATCH) scratch <= i_acc.wdat;
         if (reg_sel == periph_pkg::SYS_SWIRQ)   sw_irq  <= i_acc.wdat[1:0];
      end
   end

   always_comb begin
      case (reg_sel)
         periph_pkg::SYS_VER:     o_rdat = periph_pkg::SYS_VERSION;
         periph_pkg::SYS_SCRATCH: o_rdat = scratch;
         periph_pkg::SYS_STATUS:  o_rdat = {30'd0, i_init_error, i_init_done};
         periph_pkg::SYS_SWIRQ:   o_rdat = {30'd0, sw_irq};
         default:                 o_rdat = '0;
      endcase
   end

   // Interrupt vector
   always_comb begin
      o_irq                       = '0;
      o_irq[periph_pkg::IRQ_GPIO] = i_gpio_irq;
      o_irq[periph_pkg::IRQ_PWM]  = i_pwm_irq;
      o_irq[periph_pkg::IRQ_SW3]  = sw_irq[0];
      o_irq[periph_pkg::IRQ_SW4]  = sw_irq[1];
   end

endmodule

// File: hw/gpio_bank.sv
// GPIO output, output enable, input sampling and rising-edge interrupt registers
`timescale 1ns/10ps

module gpio_bank (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  bus_pkg::reg_acc_t                i_acc,
   output logic [bus_pkg::DATA_W-1:0]       o_rdat,
   input  logic [periph_pkg::GPIO_W-1:0]    i_gpio,
   output logic [periph_pkg::GPIO_W-1:0]    o_gpio,
   output logic [periph_pkg::GPIO_W-1:0]    o_gpio_oe,
   output logic                             o_irq
);

   periph_pkg::gpio_reg_e                reg_sel;
   logic [periph_pkg::GPIO_W-1:0]        out_q;
   logic [periph_pkg::GPIO_W-1:0]        oe_q;
   logic [periph_pkg::GPIO_W-1:0]        ie_q;
   logic [periph_pkg::GPIO_W-1:0]        is_q;
   logic [periph_pkg::GPIO_W-1:0]        in_q;
   logic [periph_pkg::GPIO_W-1:0]        in_prev;
   logic [periph_pkg::GPIO_W-1:0]        rise;
   logic [periph_pkg::GPIO_W-1:0]        is_clr;

   assign reg_sel = periph_pkg::gpio_reg_e'(i_acc.off);

   // Edge against the previous sample
   assign rise   = in_q & ~in_prev;
   assign is_clr = (i_acc.wr && reg_sel == periph_pkg::GPIO_IS) ? i_acc.wdat : '0;

   // ******************************
   // Input sampling and status
   // ******************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         in_q    <= '0;
         in_prev <= '0;
         is_q    <= '0;
      end else begin
         in_q    <= i_gpio;
         in_prev <= in_q;
         // New edges win over a same-cycle clear
         is_q    <= (is_q & ~is_clr) | (rise & ie_q);
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         out_q <= '0;
         oe_q  <= '0;
         ie_q  <= '0;
      end else if (i_acc.wr) begin
         if (reg_sel == periph_pkg::GPIO_OUT) out_q <= i_acc.wdat;
         if (reg_sel == periph_pkg::GPIO_OE)  oe_q  <= i_acc.wdat;
         if (reg_sel == periph_pkg::GPIO_IE)  ie_q  <= i_acc.wdat;
      end
   end

   always_comb begin
      case (reg_sel)
         periph_pkg::GPIO_IN:  o_rdat = in_q;
         periph_pkg::GPIO_OUT: o_rdat = out_q;
         periph_pkg::GPIO_OE:  o_rdat = oe_q;
         periph_pkg::GPIO_IE:  o_rdat = ie_q;
         periph_pkg::GPIO_IS:  o_rdat = is_q;
         default:              o_rdat = '0;
      endcase
   end

   assign o_gpio    = out_q;
   assign o_gpio_oe = oe_q;
   assign o_irq     = |is_q;

endmodule

// File: hw/pwm_timer.sv
// PWM counter with high and low reference registers and wrap interrupt
`timescale 1ns/10ps

module pwm_timer (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  bus_pkg::reg_acc_t            i_acc,
   output logic [bus_pkg::DATA_W-1:0]   o_rdat,
   output logic                         o_pwm,
   output logic                         o_irq
);

   periph_pkg::pwm_reg_e          reg_sel;
   logic [bus_pkg::DATA_W-1:0]    cntr;
   logic [bus_pkg::DATA_W-1:0]    hrc;
   logic [bus_pkg::DATA_W-1:0]    lrc;
   logic                          en;
   logic                          pend;
   logic                          wrap;
   logic                          ctrl_wr;

   assign reg_sel = periph_pkg::pwm_reg_e'(i_acc.off);
   assign ctrl_wr = i_acc.wr && (reg_sel == periph_pkg::PWM_CTRL);

   // Last count of the period is LRC-1
   assign wrap = en && (cntr >= lrc - 1'b1);

   // ******************************
   // Counter
   // ******************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         cntr <= '0;
      end else if (i_acc.wr && reg_sel == periph_pkg::PWM_CNTR) begin
         cntr <= i_acc.wdat;
      end else if (wrap) begin
         cntr <= '0;
      end else if (en) begin
         cntr <= cntr + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         hrc  <= '0;
         lrc  <= '0;
         en   <= 1'b0;
         pend <= 1'b0;
      end else begin
         if (i_acc.wr && reg_sel == periph_pkg::PWM_HRC) hrc <= i_acc.wdat;
         if (i_acc.wr && reg_sel == periph_pkg::PWM_LRC) lrc <= i_acc.wdat;
         if (ctrl_wr) en <= i_acc.wdat[0];
         // Write with bit 1 low clears, a wrap sets
         pend <= (ctrl_wr ? (pend & i_acc.wdat[1]) : pend) | wrap;
      end
   end

   always_comb begin
      case (reg_sel)
         periph_pkg::PWM_CNTR: o_rdat = cntr;
         periph_pkg::PWM_HRC:  o_rdat = hrc;
         periph_pkg::PWM_LRC:  o_rdat = lrc;
         periph_pkg::PWM_CTRL: o_rdat = {30'd0, pend, en};
         default:              o_rdat = '0;
      endcase
   end

   // High for the first HRC counts of each period
   assign o_pwm = en && (cntr < hrc);
   assign o_irq = pend;

endmodule

// File: hw/periph_core.sv
// Peripheral subsystem top level with bus controller, system controller, GPIO and PWM
`timescale 1ns/10ps

module periph_core (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  bus_pkg::wb_req_t                 i_req,
   output bus_pkg::wb_rsp_t                 o_rsp,
   input  logic [periph_pkg::GPIO_W-1:0]    i_gpio,
   output logic [periph_pkg::GPIO_W-1:0]    o_gpio,
   output logic [periph_pkg::GPIO_W-1:0]    o_gpio_oe,
   output logic                             o_pwm,
   input  logic                             i_init_done,
   input  logic                             i_init_error,
   output logic [periph_pkg::IRQ_W-1:0]     o_irq
);

   bus_pkg::reg_acc_t            sys_acc;
   bus_pkg::reg_acc_t            gpio_acc;
   bus_pkg::reg_acc_t            pwm_acc;
   logic [bus_pkg::DATA_W-1:0]   sys_rdat;
   logic [bus_pkg::DATA_W-1:0]   gpio_rdat;
   logic [bus_pkg::DATA_W-1:0]   pwm_rdat;
   logic                         gpio_irq;
   logic                         pwm_irq;

   wb_decoder u_wb_decoder (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_req       (i_req),
      .o_rsp       (o_rsp),
      .o_sys_acc   (sys_acc),
      .o_gpio_acc  (gpio_acc),
      .o_pwm_acc   (pwm_acc),
      .i_sys_rdat  (sys_rdat),
      .i_gpio_rdat (gpio_rdat),
      .i_pwm_rdat  (pwm_rdat)
   );

   sys_ctrl u_sys_ctrl (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_acc        (sys_acc),
      .o_rdat       (sys_rdat),
      .i_init_done  (i_init_done),
      .i_init_error (i_init_error),
      .i_gpio_irq   (gpio_irq),
      .i_pwm_irq    (pwm_irq),
      .o_irq        (o_irq)
   );

   // GPIO leaves as separate buses, pads live in the board wrapper
   gpio_bank u_gpio_bank (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_acc     (gpio_acc),
      .o_rdat    (gpio_rdat),
      .i_gpio    (i_gpio),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe),
      .o_irq     (gpio_irq)
   );

   pwm_timer u_pwm_timer (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_acc   (pwm_acc),
      .o_rdat  (pwm_rdat),
      .o_pwm   (o_pwm),
      .o_irq   (pwm_irq)
   );

endmodule

// File: test/periph_props.sv
// Bus protocol assertions bound to the peripheral top level
`timescale 1ns/10ps

module periph_props (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  bus_pkg::wb_req_t  i_req,
   input  bus_pkg::wb_rsp_t  i_rsp
);

   // Single-cycle ack
   ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rsp.ack |=> !i_rsp.ack)
      else $error("ack stayed high for more than one cycle");

   // ack only answers a strobed cycle
   ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rsp.ack |-> $past(i_req.cyc && i_req.stb))
      else $error("ack without a preceding cyc and stb");

   err_with_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rsp.err |-> i_rsp.ack)
      else $error("err raised without ack");

endmodule

bind periph_core periph_props u_periph_props (
   .i_clk   (i_clk),
   .i_rst_n (i_rst_n),
   .i_req   (i_req),
   .i_rsp   (o_rsp)
);

// File: test/tb_periph_core.sv
// Testbench for the peripheral top level with xorshift stimulus and register model
`timescale 1ns/10ps

module tb_periph_core;

   // About 600 accesses at up to 4 cycles, PWM windows and margin
   localparam int CYCLE_LIMIT = 20000;

   logic                                 clk;
   logic                                 rst_n;
   bus_pkg::wb_req_t                     req;
   bus_pkg::wb_rsp_t                     rsp;
   logic [periph_pkg::GPIO_W-1:0]        gpio_in;
   logic [periph_pkg::GPIO_W-1:0]        gpio_out;
   logic [periph_pkg::GPIO_W-1:0]        gpio_oe;
   logic                                 pwm;
   logic                                 init_done;
   logic                                 init_error;
   logic [periph_pkg::IRQ_W-1:0]         irq;
   logic [31:0]                          rng;
   int                                   cycles;

   periph_core UUT (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_req        (req),
      .o_rsp        (rsp),
      .i_gpio       (gpio_in),
      .o_gpio       (gpio_out),
      .o_gpio_oe    (gpio_oe),
      .o_pwm        (pwm),
      .i_init_done  (init_done),
      .i_init_error (init_error),
      .o_irq        (irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ******************************
   // Hang guard
   // ******************************
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // One Wishbone access, ack expected on the second falling edge
   task automatic bus_access(input logic we, input logic [1:0] rgn, input logic [3:0] off,
                             input logic [31:0] wdat, output logic [31:0] rdat,
                             output logic err);
      int n;
      n = 0;
      @(posedge clk);
      req.cyc <= 1'b1;
      req.stb <= 1'b1;
      req.we  <= we;
      req.adr <= {rgn, off};
      req.dat <= wdat;
      do begin
         @(negedge clk);
         n++;
      end while (!rsp.ack);
      assert (n == 2) else begin
         $display("ack did not arrive one cycle after the request was presented");
         $display("TEST FAILED");
         $fatal(1);
      end
      rdat = rsp.dat;
      err  = rsp.err;
      @(posedge clk);
      req.cyc <= 1'b0;
      req.stb <= 1'b0;
      req.we  <= 1'b0;
   endtask

   task automatic write_reg(input logic [1:0] rgn, input logic [3:0] off,
                            input logic [31:0] wdat);
      logic [31:0] rd;
      logic        err;
      bus_access(1'b1, rgn, off, wdat, rd, err);
      check_value("o_rsp.err", {31'd0, err}, 32'd0);
   endtask

   task automatic read_expect(input string name, input logic [1:0] rgn,
                              input logic [3:0] off, input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      bus_access(1'b0, rgn, off, 32'd0, rd, err);
      check_value("o_rsp.err", {31'd0, err}, 32'd0);
      check_value(name, rd, exp);
   endtask

   initial begin
      logic [31:0] m_out;
      logic [31:0] m_oe;
      logic [31:0] m_ie;
      logic [31:0] m_is;
      logic [31:0] val;
      logic [31:0] rd;
      logic        err;
      int          p;
      int          h;
      int          highs;
      rng        = 32'h1092;
      cycles     = 0;
      rst_n      = 1'b0;
      req        = '0;
      gpio_in    = '0;
      init_done  = 1'b0;
      init_error = 1'b0;
      m_is       = '0;
      wait_cycles(10);
      rst_n <= 1'b1;
      wait_cycles(2);

      // Registers, status and software interrupts
      for (int i = 0; i < 40; i++) begin
         rng = xorshift32(rng);
         read_expect("SYS_VER", 2'd0, 4'd0, periph_pkg::SYS_VERSION);
         write_reg(2'd0, 4'd1, rng);
         read_expect("SYS_SCRATCH", 2'd0, 4'd1, rng);
         @(posedge clk);
         init_done  <= rng[3];
         init_error <= rng[4];
         read_expect("SYS_STATUS", 2'd0, 4'd2, {30'd0, rng[4], rng[3]});
         write_reg(2'd0, 4'd3, {30'd0, rng[6:5]});
         @(negedge clk);
         // GPIO and PWM sources are still idle here
         check_value("o_irq", {24'd0, irq}, {24'd0, 4'd0, rng[6:5], 2'd0});
      end

      // Unmapped region answers with err and zero data
      for (int i = 0; i < 20; i++) begin
         rng = xorshift32(rng);
         bus_access(rng[0], 2'd3, rng[4:1], rng, rd, err);
         check_value("o_rsp.err", {31'd0, err}, 32'd1);
         check_value("o_rsp.dat", rd, 32'd0);
      end

      // GPIO outputs and input sampling
      for (int i = 0; i < 40; i++) begin
         rng = xorshift32(rng);
         m_out = rng;
         rng = xorshift32(rng);
         m_oe = rng;
         write_reg(2'd1, 4'd1, m_out);
         write_reg(2'd1, 4'd2, m_oe);
         @(negedge clk);
         check_value("o_gpio", gpio_out, m_out);
         check_value("o_gpio_oe", gpio_oe, m_oe);
         rng = xorshift32(rng);
         @(posedge clk);
         gpio_in <= rng;
         wait_cycles(3);
         read_expect("GPIO_IN", 2'd1, 4'd0, rng);
      end

      // GPIO edge interrupts
      val = gpio_in;
      rng = xorshift32(rng);
      m_ie = rng;
      write_reg(2'd1, 4'd3, m_ie);
      for (int i = 0; i < 60; i++) begin
         rng = xorshift32(rng);
         @(posedge clk);
         gpio_in <= rng;
         m_is = m_is | (rng & ~val & m_ie);
         val = rng;
         wait_cycles(3);
         read_expect("GPIO_IS", 2'd1, 4'd4, m_is);
         @(negedge clk);
         check_value("o_irq[IRQ_GPIO]", {31'd0, irq[periph_pkg::IRQ_GPIO]},
                     {31'd0, |m_is});
         rng = xorshift32(rng);
         write_reg(2'd1, 4'd4, rng);
         m_is = m_is & ~rng;
         read_expect("GPIO_IS", 2'd1, 4'd4, m_is);
      end

      // ******************************
      // PWM duty and wrap interrupt
      // ******************************
      for (int i = 0; i < 20; i++) begin
         rng = xorshift32(rng);
         p = 4 + int'(rng % 16);
         rng = xorshift32(rng);
         h = int'(rng % 32'(p + 1));
         write_reg(2'd2, 4'd2, 32'(p));
         write_reg(2'd2, 4'd1, 32'(h));
         write_reg(2'd2, 4'd3, 32'd1);
         wait_cycles(2 * p);
         highs = 0;
         for (int c = 0; c < p; c++) begin
            @(negedge clk);
            if (pwm) highs++;
         end
         check_value("o_pwm high cycles", 32'(highs), 32'(h));
         read_expect("PWM_CTRL", 2'd2, 4'd3, 32'd3);
         @(negedge clk);
         check_value("o_irq[IRQ_PWM]", {31'd0, irq[periph_pkg::IRQ_PWM]}, 32'd1);
         // Second write clears a wrap that raced the disable
         write_reg(2'd2, 4'd3, 32'd0);
         write_reg(2'd2, 4'd3, 32'd0);
         read_expect("PWM_CTRL", 2'd2, 4'd3, 32'd0);
         @(negedge clk);
         check_value("o_irq[IRQ_PWM]", {31'd0, irq[periph_pkg::IRQ_PWM]}, 32'd0);
      end

      wait_cycles(2);
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: verilog.f
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/wb_decoder.sv
hw/sys_ctrl.sv
hw/gpio_bank.sv
hw/pwm_timer.sv
hw/periph_core.sv
test/periph_props.sv
test/tb_periph_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_periph_core
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
